// ==== list.f ====
+incdir+bench
hw/display_pkg.sv
hw/ascii_pkg.sv
hw/field_if.sv
hw/uart_tx.sv
hw/dec_formatter.sv
hw/display_sequencer.sv
hw/display_top.sv
bench/tb_display.sv

// ==== Bender.yml ====
package:
  name: display_engine

sources:
  - hw/display_pkg.sv
  - hw/ascii_pkg.sv
  - hw/field_if.sv
  - hw/uart_tx.sv
  - hw/dec_formatter.sv
  - hw/display_sequencer.sv
  - hw/display_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_display.sv

// ==== bench/tb_text_model.svh ====
// ===========================================================================
// serial capture
// ===========================================================================

// one 8N1 frame with each bit sampled near its middle on a falling clock edge
task automatic capture_byte(output logic [7:0] b, output logic frame_ok);
    @(negedge o_tx);                        // start bit begins
    repeat (CLKS_PER_BIT / 2) @(posedge clk);
    @(negedge clk);
    frame_ok = (o_tx == 1'b0);
    for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        b[i] = o_tx;                        // lsb first
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    frame_ok = frame_ok & o_tx;             // stop bit
endtask

// ===========================================================================
// expected text
// ===========================================================================
function automatic void push_text(input string s);
    for (int i = 0; i < s.len(); i++) begin
        exp_q.push_back(s[i]);
    end
endfunction

function automatic void push_number(input logic [VAL_W-1:0] v, input logic pad);
    string s;
    s = $sformatf("%0d", v);
    push_text(s);
    if (pad) begin
        for (int k = s.len(); k < COL_W; k++) begin
            exp_q.push_back(8'h20);         // pad to column width
        end
    end
endfunction

function automatic void push_crlf();
    exp_q.push_back(8'h0d);
    exp_q.push_back(8'h0a);
endfunction

// element, padding, then a space or CR LF at the end of a row
function automatic void build_matrix(input int base, input int m, input int n);
    for (int r = 0; r < m; r++) begin
        for (int c = 0; c < n; c++) begin
            push_number(mem[base + r * n + c], 1'b1);
            if (c == n - 1) push_crlf();
            else            push_text(" ");
        end
    end
endfunction

function automatic void build_summary(input int types);
    push_number(VAL_W'(i_total_count), 1'b0);
    push_text(" ");
    for (int t = 0; t < types; t++) begin
        push_text($sformatf("%0d*%0d*%0d ", tbl_m[t], tbl_n[t], tbl_cnt[t]));
    end
    push_crlf();
endfunction

// byte count first, then every byte in order
task automatic compare_text(input string name);
    int n;
    assert (rx_q.size() == exp_q.size()) else begin
        err_cnt++;
        $display("MISMATCH %s byte count expected %0d actual %0d", name, exp_q.size(),
                 rx_q.size());
    end
    n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
        assert (rx_q[i] == exp_q[i]) else begin
            err_cnt++;
            $display("MISMATCH %s byte %0d expected %h actual %h", name, i,
                     exp_q[i], rx_q[i]);
        end
    end
endtask

// ==== bench/tb_display.sv ====
module tb_display
    import display_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int CLKS_PER_BIT = 4;
    localparam int COL_W        = 10;
    localparam int MAT_M        = 3;
    localparam int MAT_N        = 4;
    localparam int SETTLE       = 12 * CLKS_PER_BIT;  // more than one frame
    // byte bound over the matrix, the summary and four scalars
    localparam int MAX_BYTES    = MAT_M * MAT_N * (COL_W + 1) + 30 + 4 * 12;
    localparam int N_REPORTS    = 7;
    localparam int WATCHDOG_T   = (MAX_BYTES * 40 + N_REPORTS * 2000) * CLK_PERIOD;

    logic               clk;
    logic               rst_n;
    logic               i_en;
    logic [MODE_W-1:0]  i_mode;
    logic [DIM_W-1:0]   i_disp_m   = '0;
    logic [DIM_W-1:0]   i_disp_n   = '0;
    logic [CNT_W-1:0]   i_disp_cnt = '0;
    logic [ADDR_W-1:0]  i_base_addr;
    logic [VAL_W-1:0]   i_rd_data  = '0;
    logic [TOTAL_W-1:0] i_total_count;
    logic [TYPE_W-1:0]  i_type_count;
    logic [VAL_W-1:0]   i_scalar;
    logic [ADDR_W-1:0]  o_rd_addr;
    logic [TYPE_W-1:0]  o_type_idx;
    logic               o_tx;
    logic               o_done;

    logic [VAL_W-1:0]   mem [2**ADDR_W];
    logic [ADDR_W-1:0]  rd_addr_q  = '0;     // address held by the memory
    logic [DIM_W-1:0]   tbl_m [2**TYPE_W];
    logic [DIM_W-1:0]   tbl_n [2**TYPE_W];
    logic [CNT_W-1:0]   tbl_cnt [2**TYPE_W];
    logic [7:0]         rx_q [$];
    logic [7:0]         exp_q [$];
    logic               lookup_on  = 1'b0;   // summary table drives the size inputs
    logic               mat_active = 1'b0;
    logic               sum_active = 1'b0;
    int                 mat_base   = 0;
    int                 err_cnt    = 0;

    `include "tb_text_model.svh"

    display_top #(
        .CLK_FREQ  (400),
        .BAUD_RATE (100),
        .COL_WIDTH (COL_W)
    ) display_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_en          (i_en),
        .i_mode        (i_mode),
        .i_disp_m      (i_disp_m),
        .i_disp_n      (i_disp_n),
        .i_disp_cnt    (i_disp_cnt),
        .i_base_addr   (i_base_addr),
        .i_rd_data     (i_rd_data),
        .i_total_count (i_total_count),
        .i_type_count  (i_type_count),
        .i_scalar      (i_scalar),
        .o_rd_addr     (o_rd_addr),
        .o_type_idx    (o_type_idx),
        .o_tx          (o_tx),
        .o_done        (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================================================
    // memory and size lookup models
    // ========================================================================
    // read data follows the address one clock later
    always @(negedge clk) begin
        rd_addr_q <= o_rd_addr;
        i_rd_data <= mem[rd_addr_q];
    end

    always @(negedge clk) begin
        if (lookup_on) begin
            i_disp_m   <= tbl_m[o_type_idx];
            i_disp_n   <= tbl_n[o_type_idx];
            i_disp_cnt <= tbl_cnt[o_type_idx];
        end else begin
            i_disp_m   <= DIM_W'(MAT_M);    // matrix under test
            i_disp_n   <= DIM_W'(MAT_N);
            i_disp_cnt <= CNT_W'(1);
        end
    end

    initial begin : rx_monitor
        logic [7:0] b;
        logic       ok;
        wait (rst_n === 1'b1);
        forever begin
            capture_byte(b, ok);
            assert (ok) else begin
                err_cnt++;
                $display("framing error on o_tx, bad start or stop bit");
            end
            rx_q.push_back(b);
        end
    end

    // ========================================================================
    // protocol checks
    // ========================================================================
    assert property (@(posedge clk) disable iff (!rst_n)
        (mat_active && $changed(o_rd_addr)) |->
        (int'(o_rd_addr) >= mat_base && int'(o_rd_addr) < mat_base + MAT_M * MAT_N))
    else begin
        err_cnt++;
        $display("o_rd_addr %0d outside the matrix at base %0d", o_rd_addr, mat_base);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        sum_active |-> (o_type_idx <= i_type_count))
    else begin
        err_cnt++;
        $display("o_type_idx %0d went past the type count", o_type_idx);
    end

    assert property (@(posedge clk) disable iff (!rst_n) (o_done && i_en) |=> o_done)
    else begin
        err_cnt++;
        $display("o_done fell while i_en was still high");
    end

    assert property (@(posedge clk) disable iff (!rst_n) (o_done && !i_en) |=> !o_done)
    else begin
        err_cnt++;
        $display("o_done stayed high after i_en dropped");
    end

    task automatic check_reset_state(input string when);
        assert (o_tx === 1'b1 && o_done === 1'b0 && o_rd_addr === '0 &&
                o_type_idx === '0) else begin
            err_cnt++;
            $display("MISMATCH %s expected %s actual tx %b done %b addr %0d idx %0d",
                     when, "tx 1 done 0 addr 0 idx 0", o_tx, o_done, o_rd_addr,
                     o_type_idx);
        end
    endtask

    // start one report, wait for done, hold i_en, then release
    task automatic run_report(input logic [MODE_W-1:0] mode);
        int got;
        rx_q.delete();
        @(negedge clk);
        i_mode = mode;
        i_en   = 1'b1;
        while (o_done !== 1'b1) @(negedge clk);   // watchdog bounds this
        repeat (SETTLE) @(negedge clk);            // last frame drains
        got = rx_q.size();
        repeat (SETTLE) @(negedge clk);
        assert (rx_q.size() == got) else begin
            err_cnt++;
            $display("bytes arrived after o_done while i_en was held");
        end
        i_en = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin
        void'($urandom(32'h49e1));
        rst_n         = 1'b0;
        i_en          = 1'b0;
        i_mode        = '0;
        i_base_addr   = '0;
        i_total_count = '0;
        i_type_count  = '0;
        i_scalar      = '0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            mem[a] = 32'h5a00_0000 ^ (a * 32'h0001_0103);
        end
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            check_reset_state("during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state("after reset");

        // 3 by 4 matrix with both extreme values
        mat_base = $urandom_range(0, 2**ADDR_W - MAT_M * MAT_N);
        for (int k = 0; k < MAT_M * MAT_N; k++) begin
            mem[mat_base + k] = $urandom();
        end
        mem[mat_base + 1] = 32'd0;
        mem[mat_base + 6] = 32'hffff_ffff;
        i_base_addr = ADDR_W'(mat_base);
        exp_q.delete();
        build_matrix(mat_base, MAT_M, MAT_N);
        mat_active = 1'b1;
        run_report(MODE_MATRIX);
        mat_active = 1'b0;
        compare_text("matrix");

        // summary over three size types
        for (int t = 0; t < 2**TYPE_W; t++) begin
            tbl_m[t]   = DIM_W'($urandom_range(1, 20));
            tbl_n[t]   = DIM_W'($urandom_range(1, 20));
            tbl_cnt[t] = CNT_W'($urandom_range(0, 3));
        end
        i_total_count = TOTAL_W'($urandom());
        i_type_count  = TYPE_W'(3);
        lookup_on     = 1'b1;
        sum_active    = 1'b1;
        exp_q.delete();
        build_summary(3);
        repeat (2) @(negedge clk);
        run_report(MODE_SUMMARY);
        sum_active = 1'b0;
        lookup_on  = 1'b0;
        compare_text("summary");

        for (int s = 0; s < 4; s++) begin
            i_scalar = (s == 0) ? 32'd0 : $urandom();
            exp_q.delete();
            push_number(i_scalar, 1'b0);          // no padding here
            push_crlf();
            run_report(MODE_SCALAR);
            compare_text("scalar");
        end

        exp_q.delete();
        run_report(3'd3);                          // unsupported mode prints nothing
        compare_text("mode 3");

        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_T);
        $display("timeout, report never finished, errors: %0d", err_cnt);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== hw/display_top.sv ====
module display_top
    import display_pkg::*;
#(
    parameter int CLK_FREQ  = 25_000_000,
    parameter int BAUD_RATE = 115_200,
    parameter int COL_WIDTH = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_en,
    input  logic [MODE_W-1:0]  i_mode,
    input  logic [DIM_W-1:0]   i_disp_m,
    input  logic [DIM_W-1:0]   i_disp_n,
    input  logic [CNT_W-1:0]   i_disp_cnt,
    input  logic [ADDR_W-1:0]  i_base_addr,
    input  logic [VAL_W-1:0]   i_rd_data,
    input  logic [TOTAL_W-1:0] i_total_count,
    input  logic [TYPE_W-1:0]  i_type_count,
    input  logic [VAL_W-1:0]   i_scalar,
    output logic [ADDR_W-1:0]  o_rd_addr,
    output logic [TYPE_W-1:0]  o_type_idx,
    output logic               o_tx,
    output logic               o_done
);

    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    field_if fld_if ();

    // walks the report, one field at a time
    display_sequencer display_sequencer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_en          (i_en),
        .i_mode        (i_mode),
        .i_disp_m      (i_disp_m),
        .i_disp_n      (i_disp_n),
        .i_disp_cnt    (i_disp_cnt),
        .i_base_addr   (i_base_addr),
        .i_rd_data     (i_rd_data),
        .i_total_count (i_total_count),
        .i_type_count  (i_type_count),
        .i_scalar      (i_scalar),
        .o_rd_addr     (o_rd_addr),
        .o_type_idx    (o_type_idx),
        .o_done        (o_done),
        .fld           (fld_if.seq)
    );

    dec_formatter #(
        .COL_WIDTH (COL_WIDTH)
    ) dec_formatter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fld        (fld_if.fmt),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data)
    );

    uart_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) uart_tx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_tx    (o_tx),
        .o_busy  (tx_busy)
    );

endmodule

// ==== hw/display_sequencer.sv ====
module display_sequencer
    import display_pkg::*;
    import ascii_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_en,
    input  logic [MODE_W-1:0]  i_mode,
    input  logic [DIM_W-1:0]   i_disp_m,
    input  logic [DIM_W-1:0]   i_disp_n,
    input  logic [CNT_W-1:0]   i_disp_cnt,
    input  logic [ADDR_W-1:0]  i_base_addr,
    input  logic [VAL_W-1:0]   i_rd_data,
    input  logic [TOTAL_W-1:0] i_total_count,
    input  logic [TYPE_W-1:0]  i_type_count,
    input  logic [VAL_W-1:0]   i_scalar,
    output logic [ADDR_W-1:0]  o_rd_addr,
    output logic [TYPE_W-1:0]  o_type_idx,
    output logic               o_done,
    field_if.seq               fld
);

    typedef enum logic [4:0] {
        S_IDLE, S_DECODE,
        S_MAT_ADDR, S_MAT_WAIT, S_MAT_ELEM, S_MAT_SEP, S_MAT_LF,
        S_SUM_TOTAL, S_SUM_SP1, S_SUM_CHECK, S_SUM_M, S_SUM_STAR1,
        S_SUM_N, S_SUM_STAR2, S_SUM_CNT, S_SUM_SP2,
        S_SCALAR, S_CR, S_LF, S_DONE
    } seq_state_t;

    seq_state_t           state;
    seq_state_t           f_next;       // successor once the field is done
    logic                 f_field;      // state prints one field
    logic                 pend_q;       // field outstanding at the formatter
    logic [DIM_W-1:0]     row_q;
    logic [DIM_W-1:0]     col_q;
    logic [VAL_W-1:0]     elem_q;
    logic [2*DIM_W-1:0]   row_off;
    logic [ADDR_W-1:0]    mat_addr;
    logic                 last_col;
    logic                 last_row;

    assign row_off  = row_q * i_disp_n;
    assign mat_addr = i_base_addr + ADDR_W'(row_off) + ADDR_W'(col_q);
    assign last_col = (col_q == i_disp_n - 1'b1);
    assign last_row = (row_q == i_disp_m - 1'b1);
    assign o_done   = (state == S_DONE);   // held until i_en drops

    // =========================================================================
    // field contents per state, stable while the field is outstanding
    // =========================================================================
    always_comb begin
        f_field    = 1'b1;
        f_next     = state;
        fld.kind   = FIELD_CHAR;
        fld.value  = '0;
        fld.pad_en = 1'b0;
        case (state)
            S_MAT_ELEM: begin
                fld.kind   = FIELD_NUM;
                fld.value  = elem_q;
                fld.pad_en = 1'b1;
                f_next     = S_MAT_SEP;
            end
            S_MAT_SEP: begin
                fld.value = VAL_W'(last_col ? CH_CR : CH_SPACE);
                f_next    = last_col ? S_MAT_LF : S_MAT_ADDR;
            end
            S_MAT_LF: begin
                fld.value = VAL_W'(CH_LF);
                f_next    = last_row ? S_DONE : S_MAT_ADDR;
            end
            S_SUM_TOTAL: begin
                fld.kind  = FIELD_NUM;
                fld.value = VAL_W'(i_total_count);
                f_next    = S_SUM_SP1;
            end
            S_SUM_SP1: begin
                fld.value = VAL_W'(CH_SPACE);
                f_next    = S_SUM_CHECK;
            end
            S_SUM_M: begin
                fld.kind  = FIELD_NUM;
                fld.value = VAL_W'(i_disp_m);
                f_next    = S_SUM_STAR1;
            end
            S_SUM_STAR1: begin
                fld.value = VAL_W'(CH_STAR);
                f_next    = S_SUM_N;
            end
            S_SUM_N: begin
                fld.kind  = FIELD_NUM;
                fld.value = VAL_W'(i_disp_n);
                f_next    = S_SUM_STAR2;
            end
            S_SUM_STAR2: begin
                fld.value = VAL_W'(CH_STAR);
                f_next    = S_SUM_CNT;
            end
            S_SUM_CNT: begin
                fld.kind  = FIELD_NUM;
                fld.value = VAL_W'(i_disp_cnt);
                f_next    = S_SUM_SP2;
            end
            S_SUM_SP2: begin
                fld.value = VAL_W'(CH_SPACE);
                f_next    = S_SUM_CHECK;
            end
            S_SCALAR: begin
                fld.kind  = FIELD_NUM;     // unpadded
                fld.value = i_scalar;
                f_next    = S_CR;
            end
            S_CR: begin
                fld.value = VAL_W'(CH_CR);
                f_next    = S_LF;
            end
            S_LF: begin
                fld.value = VAL_W'(CH_LF);
                f_next    = S_DONE;
            end
            default: f_field = 1'b0;
        endcase
    end

    // =========================================================================
    // state walk
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            pend_q     <= 1'b0;
            fld.start  <= 1'b0;
            row_q      <= '0;
            col_q      <= '0;
            o_rd_addr  <= '0;
            o_type_idx <= '0;
        end else begin
            fld.start <= 1'b0;
            if (f_field) begin
                if (!pend_q) begin
                    fld.start <= 1'b1;
                    pend_q    <= 1'b1;
                end else if (fld.done) begin
                    pend_q <= 1'b0;
                    state  <= f_next;
                    case (state)
                        S_MAT_SEP: if (!last_col) col_q <= col_q + 1'b1;
                        S_MAT_LF: begin
                            col_q <= '0;
                            row_q <= row_q + 1'b1;
                        end
                        S_SUM_SP2: o_type_idx <= o_type_idx + 1'b1;   // next size type
                        default: ;
                    endcase
                end
            end else begin
                case (state)
                    S_IDLE: if (i_en) state <= S_DECODE;
                    S_DECODE: begin
                        row_q      <= '0;
                        col_q      <= '0;
                        o_type_idx <= '0;
                        case (i_mode)
                            MODE_MATRIX:
                                if (i_disp_m == '0 || i_disp_n == '0) state <= S_DONE;
                                else                                  state <= S_MAT_ADDR;
                            MODE_SUMMARY: state <= S_SUM_TOTAL;
                            MODE_SCALAR:  state <= S_SCALAR;
                            default:      state <= S_DONE;      // nothing to print
                        endcase
                    end
                    S_MAT_ADDR: begin
                        o_rd_addr <= mat_addr;
                        state     <= S_MAT_WAIT;
                    end
                    S_MAT_WAIT: state <= S_MAT_ELEM;   // memory read latency
                    S_SUM_CHECK:
                        state <= (o_type_idx < i_type_count) ? S_SUM_M : S_CR;
                    S_DONE: if (!i_en) state <= S_IDLE;
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // element sampled two cycles after the address update
    always_ff @(posedge clk) begin
        if (state == S_MAT_ELEM && !pend_q) elem_q <= i_rd_data;
    end

endmodule

// ==== hw/dec_formatter.sv ====
module dec_formatter
    import display_pkg::*;
    import ascii_pkg::*;
#(
    parameter int COL_WIDTH = 10
) (
    input  logic       clk,
    input  logic       rst_n,
    field_if.fmt       fld,
    input  logic       i_tx_busy,
    output logic       o_tx_start,
    output logic [7:0] o_tx_data
);

    localparam int PTR_W = $clog2(MAX_DIGITS);
    localparam int OUT_W = $clog2(MAX_DIGITS + COL_WIDTH + 1);

    typedef enum logic [2:0] {
        F_IDLE,
        F_CHAR,
        F_CONV,
        F_DIGIT,
        F_PAD
    } fmt_state_t;

    fmt_state_t        state;
    logic [VAL_W-1:0]  temp_q;                   // remaining quotient
    logic [7:0]        dig_buf [MAX_DIGITS];     // ascii digits, lsd at 0
    logic [PTR_W-1:0]  ptr_q;
    logic [OUT_W-1:0]  out_cnt;                  // chars sent in this field
    logic [OUT_W-1:0]  next_cnt;
    logic              tx_ready;

    // no strobe two cycles in a row, busy only rises after the strobe
    assign tx_ready = ~i_tx_busy & ~o_tx_start;
    assign next_cnt = out_cnt + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= F_IDLE;
            ptr_q      <= '0;
            out_cnt    <= '0;
            o_tx_start <= 1'b0;
            o_tx_data  <= '0;
            fld.done   <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            fld.done   <= 1'b0;
            case (state)
                F_IDLE: if (fld.start) begin
                    ptr_q   <= '0;
                    out_cnt <= '0;
                    state   <= (fld.kind == FIELD_CHAR) ? F_CHAR : F_CONV;
                end
                F_CHAR: if (tx_ready) begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= fld.value[7:0];
                    fld.done   <= 1'b1;
                    state      <= F_IDLE;
                end
                F_CONV: begin                       // one digit per cycle
                    if (temp_q < VAL_W'(10)) state <= F_DIGIT;
                    else                     ptr_q <= ptr_q + 1'b1;
                end
                F_DIGIT: if (tx_ready) begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= dig_buf[ptr_q];  // msd first
                    out_cnt    <= next_cnt;
                    if (ptr_q != '0) begin
                        ptr_q <= ptr_q - 1'b1;
                    end else if (fld.pad_en && next_cnt < OUT_W'(COL_WIDTH)) begin
                        state <= F_PAD;
                    end else begin
                        fld.done <= 1'b1;
                        state    <= F_IDLE;
                    end
                end
                F_PAD: if (tx_ready) begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= CH_SPACE;
                    out_cnt    <= next_cnt;
                    if (next_cnt >= OUT_W'(COL_WIDTH)) begin
                        fld.done <= 1'b1;
                        state    <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // repeated divide by ten
    always_ff @(posedge clk) begin
        if (state == F_IDLE && fld.start) begin
            temp_q <= fld.value;
        end else if (state == F_CONV) begin
            dig_buf[ptr_q] <= CH_ZERO + 8'(temp_q % VAL_W'(10));
            temp_q         <= temp_q / VAL_W'(10);
        end
    end

endmodule

// ==== hw/uart_tx.sv ====
module uart_tx #(
    parameter int CLK_FREQ  = 25_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_start,
    input  logic [7:0] i_data,
    output logic       o_tx,
    output logic       o_busy
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT + 1);
    localparam logic [3:0] STOP_IDX = 4'd9;   // start + 8 data bits before stop

    logic [BAUD_W-1:0] baud_q;
    logic [3:0]        bit_q;       // bits finished so far
    logic [8:0]        shift_q;     // data bits, then stop bit
    logic              bit_end;

    assign bit_end = (baud_q == BAUD_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_tx   <= 1'b1;         // line idles high
            o_busy <= 1'b0;
            baud_q <= '0;
            bit_q  <= '0;
        end else if (!o_busy) begin
            if (i_start) begin
                o_tx   <= 1'b0;     // start bit
                o_busy <= 1'b1;
                baud_q <= '0;
                bit_q  <= '0;
            end
        end else if (bit_end) begin
            baud_q <= '0;
            if (bit_q == STOP_IDX) begin
                o_busy <= 1'b0;     // stop bit done, o_tx already high
            end else begin
                o_tx  <= shift_q[0];
                bit_q <= bit_q + 4'd1;
            end
        end else begin
            baud_q <= baud_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!o_busy && i_start) begin
            shift_q <= {1'b1, i_data};
        end else if (o_busy && bit_end) begin
            shift_q <= {1'b1, shift_q[8:1]};    // lsb first
        end
    end

endmodule

// ==== hw/field_if.sv ====
interface field_if
    import display_pkg::*;
();

    logic                start;     // one cycle request pulse
    field_kind_t         kind;
    logic [VAL_W-1:0]    value;
    logic                pad_en;    // pad number to column width
    logic                done;      // pulse after last byte handed off

    modport seq (
        output start, kind, value, pad_en,
        input  done
    );

    modport fmt (
        input  start, kind, value, pad_en,
        output done
    );

endinterface

// ==== hw/ascii_pkg.sv ====
package ascii_pkg;

    localparam logic [7:0] CH_SPACE = 8'h20;
    localparam logic [7:0] CH_STAR  = 8'h2a;
    localparam logic [7:0] CH_CR    = 8'h0d;
    localparam logic [7:0] CH_LF    = 8'h0a;

    // added to a 0..9 digit value
    localparam logic [7:0] CH_ZERO  = 8'h30;

endpackage

// ==== hw/display_pkg.sv ====
package display_pkg;

    // =========================================================================
    // data widths
    // =========================================================================
    localparam int VAL_W   = 32;    // matrix elements, printed values
    localparam int DIM_W   = 8;     // row / column counts
    localparam int ADDR_W  = 9;     // storage address
    localparam int CNT_W   = 2;     // matrices per size type
    localparam int TOTAL_W = 8;     // system total
    localparam int TYPE_W  = 5;     // size type index and count
    localparam int MODE_W  = 3;

    // largest 32 bit value has ten decimal digits
    localparam int MAX_DIGITS = 10;

    typedef enum logic [MODE_W-1:0] {
        MODE_MATRIX  = 3'd0,
        MODE_SUMMARY = 3'd2,
        MODE_SCALAR  = 3'd4
    } disp_mode_t;

    typedef enum logic {
        FIELD_CHAR = 1'b0,      // value[7:0] sent as one byte
        FIELD_NUM  = 1'b1       // value printed in decimal
    } field_kind_t;

endpackage
